//--- verif/dma_tests.txt
// op(0 write, 1 read, 2 write sent with next read, f end) id addr size wdata strb
// ecc(1 inject) resp(0 okay, 2 slverr, 3 decerr) rdata
2 1 f0040000 3 1122334455667788 ff 0 0 0
1 2 f0040100 3 0 0 0 0 f00401000ffbfeff
0 3 f0040008 3 a1a2a3a4a5a6a7a8 ff 0 0 0
0 4 f0040010 2 00000000cafef00d 0f 0 0 0
0 5 f0040010 3 deadbeef00000000 f0 0 0 0
0 6 f004001c 2 5566778800000000 f0 0 0 0
0 7 f0060000 3 0 ff 0 3 0
0 8 f0040003 2 0 0f 0 2 0
0 9 f0040020 0 0 01 0 2 0
0 a f0040028 3 0 3c 0 2 0
1 1 f0040000 3 0 0 0 0 1122334455667788
1 2 f0040008 3 0 0 0 0 a1a2a3a4a5a6a7a8
1 3 f0040010 2 0 0 0 0 deadbeefcafef00d
1 4 f0040018 3 0 0 0 0 556677880ffbffe7
1 5 f0050010 3 0 0 0 3 00000000f0050010
1 6 f0040001 1 0 0 0 2 00000000f0040001
1 7 f0040006 3 0 0 0 2 00000000f0040006
1 8 f0040002 2 0 0 0 2 00000000f0040002
1 9 f0040008 3 0 0 1 2 00000000f0040008
1 a f0040000 0 0 0 0 0 1122334455667788
1 b f003fff8 3 0 0 0 3 00000000f003fff8
2 c f0040030 3 0f0e0d0c0b0a0908 ff 0 0 0
1 d f0040008 3 0 0 0 0 a1a2a3a4a5a6a7a8
1 e f0040030 3 0 0 0 0 0f0e0d0c0b0a0908
f 0 0 0 0 0 0 0 0

//--- compile.f
+incdir+logic
logic/dma_pkg.sv
logic/dma_chan_hold.sv
logic/dma_bus_decode.sv
logic/dma_entry_exec.sv
logic/dma_rsp_result.sv
logic/dma_ctrl.sv
verif/dma_ctrl_tb.sv

//--- Makefile
# Verilator build and run for the DMA slave port testbench

VERILATOR ?= verilator
TOP ?= dma_ctrl_tb
FILELIST ?= compile.f
BUILD_DIR ?= obj_dir
LOG ?= sim.log
VFLAGS ?= --binary --timing --assert -j 0
PASS_TEXT ?= Verification passed

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

run: compile
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@grep -q "$(PASS_TEXT)" $(LOG) || (echo "simulation did not pass, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- verif/dma_ctrl_tb.sv
`include "dma_settings.svh"
`default_nettype none
`timescale 1ns/1ps

module dma_ctrl_tb;

   import dma_pkg::*;

   localparam int FIELDS = 9;   // Words per test line
   localparam int MAX_TESTS = 64;
   localparam int CYCLES_PER_TEST = 200;
   localparam int MEM_WORDS = `DMA_DCCM_KB * 1024 / 8;
   localparam addr_t DCCM_BASE = `DMA_DCCM_BASE;
   localparam logic [63:0] END_OP = 64'hf;

   logic clk, rst_n;
   logic axi_aw_valid, axi_aw_ready, axi_w_valid, axi_w_ready, axi_ar_valid, axi_ar_ready;
   axi_id_t axi_aw_id, axi_ar_id, axi_bid, axi_rid;
   addr_t axi_aw_addr, axi_ar_addr, mem_addr;
   axi_size_t axi_aw_size, axi_ar_size, mem_sz;
   data_t axi_w_data, axi_rdata, mem_rdata, mem_wdata;
   strb_t axi_w_strb;
   logic axi_bready, axi_bvalid, axi_rready, axi_rvalid, axi_rlast;
   axi_resp_t axi_bresp, axi_rresp;
   logic mem_ready, mem_rvalid, mem_ecc_error, mem_req, mem_write, dma_active;
   ptr_t mem_rtag, mem_tag;

   logic [63:0] tests [0:FIELDS*MAX_TESTS-1];
   int num_tests;
   int cycle_count;
   int timeout_limit;
   int acc_wr, acc_rd, done_wr, done_rd;

   // Expected responses per channel
   axi_id_t b_exp_id [$];
   axi_resp_t b_exp_resp [$];
   axi_id_t r_exp_id [$];
   axi_resp_t r_exp_resp [$];
   data_t r_exp_data [$];
   logic ecc_q [$];   // One flag per read that reaches the DCCM
   logic seen_kind [$];   // Set for B, clear for R

   // DCCM model state
   data_t dccm [MEM_WORDS];
   logic req_seen, req_write, req_ecc;
   addr_t req_addr;
   axi_size_t req_sz;
   data_t req_wdata, req_rdata;
   ptr_t req_tag;
   logic pipe_valid, pipe_ecc;
   ptr_t pipe_tag;
   data_t pipe_data;

   dma_ctrl UUT (
      .clk(clk), .rst_n(rst_n),
      .axi_aw_valid(axi_aw_valid), .axi_aw_id(axi_aw_id), .axi_aw_addr(axi_aw_addr),
      .axi_aw_size(axi_aw_size), .axi_aw_ready(axi_aw_ready),
      .axi_w_valid(axi_w_valid), .axi_w_data(axi_w_data), .axi_w_strb(axi_w_strb),
      .axi_w_ready(axi_w_ready),
      .axi_ar_valid(axi_ar_valid), .axi_ar_id(axi_ar_id), .axi_ar_addr(axi_ar_addr),
      .axi_ar_size(axi_ar_size), .axi_ar_ready(axi_ar_ready),
      .axi_bready(axi_bready), .axi_bvalid(axi_bvalid), .axi_bid(axi_bid),
      .axi_bresp(axi_bresp),
      .axi_rready(axi_rready), .axi_rvalid(axi_rvalid), .axi_rid(axi_rid),
      .axi_rresp(axi_rresp), .axi_rdata(axi_rdata), .axi_rlast(axi_rlast),
      .mem_ready(mem_ready), .mem_rvalid(mem_rvalid), .mem_rtag(mem_rtag),
      .mem_rdata(mem_rdata), .mem_ecc_error(mem_ecc_error),
      .mem_req(mem_req), .mem_tag(mem_tag), .mem_addr(mem_addr), .mem_sz(mem_sz),
      .mem_write(mem_write), .mem_wdata(mem_wdata), .dma_active(dma_active)
   );

   always #2 clk = ~clk;

   always @(posedge clk) begin
      cycle_count++;
      if (cycle_count >= timeout_limit) begin
         $display("timeout after %0d cycles with transactions still open", cycle_count);
         $display("Verification failed");
         $fatal(1, "run did not finish in time");
      end
   end

   // ********************
   // Compare tasks
   // ********************
   task automatic check_b(input dma_pkg::axi_id_t got_id, input dma_pkg::axi_resp_t got_resp);
      axi_id_t exp_id;
      axi_resp_t exp_resp;
      if (b_exp_id.size() == 0) begin
         $display("write response with id %0h came at %0d ns with no write open", got_id, $time);
         $display("Verification failed");
         $fatal(1, "unexpected write response");
      end else begin
         exp_id = b_exp_id.pop_front();
         exp_resp = b_exp_resp.pop_front();
         if (got_id !== exp_id || got_resp !== exp_resp) begin
            $display("error at %0d ns: B id %0h resp %0h, expected id %0h resp %0h",
                     $time, got_id, got_resp, exp_id, exp_resp);
            $display("Verification failed");
            $fatal(1, "write response mismatch");
         end
      end
   endtask

   task automatic check_r(input dma_pkg::axi_id_t got_id, input dma_pkg::axi_resp_t got_resp,
                          input dma_pkg::data_t got_data);
      axi_id_t exp_id;
      axi_resp_t exp_resp;
      data_t exp_data;
      if (r_exp_id.size() == 0) begin
         $display("read response with id %0h came at %0d ns with no read open", got_id, $time);
         $display("Verification failed");
         $fatal(1, "unexpected read response");
      end else begin
         exp_id = r_exp_id.pop_front();
         exp_resp = r_exp_resp.pop_front();
         exp_data = r_exp_data.pop_front();
         if (got_id !== exp_id || got_resp !== exp_resp || got_data !== exp_data) begin
            $display("error at %0d ns: R id %0h resp %0h data %h, expected id %0h resp %0h data %h",
                     $time, got_id, got_resp, got_data, exp_id, exp_resp, exp_data);
            $display("Verification failed");
            $fatal(1, "read response mismatch");
         end
      end
   endtask

   // Handshakes are counted mid-cycle and complete at the next rising edge
   always @(negedge clk) begin
      if (rst_n) begin
         if ((acc_wr - done_wr) >= 3 && axi_aw_ready) begin
            $display("write address still ready at %0d ns with entries and hold full", $time);
            $display("Verification failed");
            $fatal(1, "write back-pressure lost");
         end
         if ((acc_rd - done_rd) >= 3 && axi_ar_ready) begin
            $display("read address still ready at %0d ns with entries and hold full", $time);
            $display("Verification failed");
            $fatal(1, "read back-pressure lost");
         end
         if (axi_aw_valid && axi_aw_ready) acc_wr++;
         if (axi_ar_valid && axi_ar_ready) acc_rd++;
         if (axi_bvalid && axi_bready) begin
            check_b(axi_bid, axi_bresp);
            done_wr++;
            seen_kind.push_back(1'b1);
         end
         if (axi_rvalid && axi_rready) begin
            if (!axi_rlast) begin
               $display("read response at %0d ns came without rlast", $time);
               $display("Verification failed");
               $fatal(1, "missing rlast");
            end
            check_r(axi_rid, axi_rresp, axi_rdata);
            done_rd++;
            seen_kind.push_back(1'b0);
         end
      end
   end

   // ********************
   // DCCM model
   // ********************
   function automatic int dccm_index(input addr_t a);
      dccm_index = int'((a - DCCM_BASE) >> 3);
   endfunction

   task automatic store_write(input addr_t a, input axi_size_t sz, input data_t d);
      case (sz)
         3'd3: dccm[dccm_index(a)] = d;
         3'd2: begin
            if (a[2]) dccm[dccm_index(a)][63:32] = d[63:32];   // Upper word lane
            else dccm[dccm_index(a)][31:0] = d[31:0];
         end
         default: begin
            $display("DCCM write of size %0d at %0d ns is neither word nor dword", sz, $time);
            $display("Verification failed");
            $fatal(1, "bad DCCM write size");
         end
      endcase
   endtask

   always @(negedge clk) begin
      if (rst_n && mem_req && !mem_ready) begin
         $display("DCCM request at %0d ns while the DCCM was not ready", $time);
         $display("Verification failed");
         $fatal(1, "request without ready");
      end else if (rst_n && mem_req) begin
         req_seen = 1'b1;
         req_write = mem_write;
         req_addr = mem_addr;
         req_sz = mem_sz;
         req_wdata = mem_wdata;
         req_tag = mem_tag;
         req_rdata = dccm[dccm_index(mem_addr)];
         if (!mem_write) begin
            if (ecc_q.size() == 0) begin
               $display("DCCM read at %0d ns for a request that should fail its checks", $time);
               $display("Verification failed");
               $fatal(1, "unexpected DCCM read");
            end else begin
               req_ecc = ecc_q.pop_front();
            end
         end
      end
   end

   always @(posedge clk) begin
      #1;
      mem_ready = ($urandom % 4) != 0;
      if ($urandom % 6 == 0) axi_bready = ~axi_bready;   // Random stretches of back-pressure
      if ($urandom % 6 == 0) axi_rready = ~axi_rready;
      mem_rvalid = pipe_valid;
      mem_rtag = pipe_tag;
      mem_rdata = pipe_data;
      mem_ecc_error = pipe_valid & pipe_ecc;
      pipe_valid = req_seen & ~req_write;   // Read data two cycles after issue
      pipe_tag = req_tag;
      pipe_data = req_rdata;
      pipe_ecc = req_ecc;
      if (req_seen && req_write) store_write(req_addr, req_sz, req_wdata);
      req_seen = 1'b0;
   end

   // ********************
   // Drivers
   // ********************
   task automatic load_write(input int base);
      axi_aw_valid = 1'b1;
      axi_aw_id = axi_id_t'(tests[base+1]);
      axi_aw_addr = addr_t'(tests[base+2]);
      axi_aw_size = axi_size_t'(tests[base+3]);
      axi_w_valid = 1'b1;
      axi_w_data = tests[base+4];
      axi_w_strb = strb_t'(tests[base+5]);
      b_exp_id.push_back(axi_aw_id);
      b_exp_resp.push_back(axi_resp_t'(tests[base+7]));
   endtask

   task automatic load_read(input int base);
      logic ecc;
      axi_resp_t resp;
      ecc = tests[base+6][0];
      resp = axi_resp_t'(tests[base+7]);
      axi_ar_valid = 1'b1;
      axi_ar_id = axi_id_t'(tests[base+1]);
      axi_ar_addr = addr_t'(tests[base+2]);
      axi_ar_size = axi_size_t'(tests[base+3]);
      r_exp_id.push_back(axi_ar_id);
      r_exp_resp.push_back(resp);
      r_exp_data.push_back(tests[base+8]);
      if (ecc || resp == `DMA_RESP_OKAY) ecc_q.push_back(ecc);   // Passes checks, so it is issued
   endtask

   task automatic wait_accept(input logic want_wr, input logic want_rd);
      logic wr_left, rd_left, wr_go, rd_go;
      wr_left = want_wr;
      rd_left = want_rd;
      while (wr_left || rd_left) begin
         @(negedge clk);
         wr_go = wr_left & axi_aw_ready & axi_w_ready;
         rd_go = rd_left & axi_ar_ready;
         @(posedge clk);
         #1;
         if (wr_go) begin
            axi_aw_valid = 1'b0;
            axi_w_valid = 1'b0;
            wr_left = 1'b0;
         end
         if (rd_go) begin
            axi_ar_valid = 1'b0;
            rd_left = 1'b0;
         end
      end
   endtask

   task automatic wait_idle();
      @(negedge clk);
      while (dma_active || b_exp_id.size() != 0 || r_exp_id.size() != 0) @(negedge clk);
      @(posedge clk);
      #1;
   endtask

   // AW/W and AR offered together with the order set by the priority bit
   task automatic run_pair(input int t);
      logic write_first;
      write_first = (t % 2) == 0;   // Bit flips on every command and starts at write
      wait_idle();
      seen_kind.delete();
      load_write(t * FIELDS);
      load_read((t + 1) * FIELDS);
      wait_accept(1'b1, 1'b1);
      wait_idle();
      if (seen_kind.size() < 2 || seen_kind[0] != write_first) begin
         $display("error at %0d ns: pair at line %0d answered in the wrong order, expected %s first",
                  $time, t, write_first ? "write" : "read");
         $display("Verification failed");
         $fatal(1, "pair order mismatch");
      end
   endtask

   initial begin
      int unsigned seed_draw;
      int t;
      int base;
      logic is_write, last_write, have_last;
      addr_t fill_addr;
      seed_draw = $urandom(32'ha09ed075);
      clk = 1'b0;
      rst_n = 1'b0;
      axi_aw_valid = 1'b0;
      axi_aw_id = '0;
      axi_aw_addr = '0;
      axi_aw_size = '0;
      axi_w_valid = 1'b0;
      axi_w_data = '0;
      axi_w_strb = '0;
      axi_ar_valid = 1'b0;
      axi_ar_id = '0;
      axi_ar_addr = '0;
      axi_ar_size = '0;
      axi_bready = 1'b1;
      axi_rready = 1'b1;
      mem_ready = 1'b0;
      mem_rvalid = 1'b0;
      mem_rtag = '0;
      mem_rdata = '0;
      mem_ecc_error = 1'b0;
      req_seen = 1'b0;
      req_ecc = 1'b0;
      pipe_valid = 1'b0;
      pipe_ecc = 1'b0;
      pipe_tag = '0;
      pipe_data = '0;
      cycle_count = 0;
      timeout_limit = CYCLES_PER_TEST;
      acc_wr = 0;
      acc_rd = 0;
      done_wr = 0;
      done_rd = 0;
      for (int i = 0; i < MEM_WORDS; i++) begin
         fill_addr = DCCM_BASE + addr_t'(i * 8);
         dccm[i] = {fill_addr, ~fill_addr};   // Byte address over its inverse
      end

      for (int i = 0; i < FIELDS * MAX_TESTS; i++) tests[i] = END_OP;
      $readmemh("verif/dma_tests.txt", tests);
      num_tests = 0;
      while (num_tests < MAX_TESTS && tests[num_tests * FIELDS] != END_OP) num_tests++;
      if (num_tests == 0) begin
         $display("no test lines could be read from verif/dma_tests.txt");
         $display("Verification failed");
         $fatal(1, "empty test file");
      end
      timeout_limit = CYCLES_PER_TEST * num_tests;

      repeat (8) @(posedge clk);
      #1;
      rst_n = 1'b1;
      @(negedge clk);
      if (axi_bvalid || axi_rvalid || mem_req || !axi_aw_ready || !axi_w_ready || !axi_ar_ready)
      begin
         $display("error at %0d ns: outputs are not in their reset state", $time);
         $display("Verification failed");
         $fatal(1, "reset state mismatch");
      end
      @(posedge clk);
      #1;

      t = 0;
      have_last = 1'b0;
      last_write = 1'b0;
      while (t < num_tests) begin
         base = t * FIELDS;
         if (tests[base] == 64'h2) begin
            run_pair(t);
            have_last = 1'b0;
            t = t + 2;
         end else begin
            is_write = tests[base] == 64'h0;
            if (have_last && is_write != last_write) wait_idle();   // Keeps B and R apart
            if (is_write) begin
               load_write(base);
               wait_accept(1'b1, 1'b0);
            end else begin
               load_read(base);
               wait_accept(1'b0, 1'b1);
            end
            last_write = is_write;
            have_last = 1'b1;
            t = t + 1;
         end
      end
      wait_idle();

      if (done_wr + done_rd != num_tests) begin
         $display("only %0d of %0d transactions were answered", done_wr + done_rd, num_tests);
         $display("Verification failed");
         $fatal(1, "transactions lost");
      end else begin
         $display("Verification passed");
         $finish;
      end
   end

endmodule

`default_nettype wire

//--- logic/dma_ctrl.sv
`default_nettype none
`timescale 1ns/1ps

module dma_ctrl (
   input logic clk,
   input logic rst_n,
   // AXI write address and data
   input logic axi_aw_valid,
   input dma_pkg::axi_id_t axi_aw_id,
   input dma_pkg::addr_t axi_aw_addr,
   input dma_pkg::axi_size_t axi_aw_size,
   output logic axi_aw_ready,
   input logic axi_w_valid,
   input dma_pkg::data_t axi_w_data,
   input dma_pkg::strb_t axi_w_strb,
   output logic axi_w_ready,
   // AXI read address
   input logic axi_ar_valid,
   input dma_pkg::axi_id_t axi_ar_id,
   input dma_pkg::addr_t axi_ar_addr,
   input dma_pkg::axi_size_t axi_ar_size,
   output logic axi_ar_ready,
   // AXI responses
   input logic axi_bready,
   output logic axi_bvalid,
   output dma_pkg::axi_id_t axi_bid,
   output dma_pkg::axi_resp_t axi_bresp,
   input logic axi_rready,
   output logic axi_rvalid,
   output dma_pkg::axi_id_t axi_rid,
   output dma_pkg::axi_resp_t axi_rresp,
   output dma_pkg::data_t axi_rdata,
   output logic axi_rlast,
   // DCCM
   input logic mem_ready,
   input logic mem_rvalid,
   input dma_pkg::ptr_t mem_rtag,
   input dma_pkg::data_t mem_rdata,
   input logic mem_ecc_error,
   output logic mem_req,
   output dma_pkg::ptr_t mem_tag,
   output dma_pkg::addr_t mem_addr,
   output dma_pkg::axi_size_t mem_sz,
   output logic mem_write,
   output dma_pkg::data_t mem_wdata,
   output logic dma_active
);

   import dma_pkg::*;

   logic cmd_valid, cmd_ready;
   bus_cmd_t cmd;
   logic held_any, busy;
   logic rsp_valid, rsp_write, rsp_taken;
   axi_id_t rsp_id;
   axi_resp_t rsp_code;
   data_t rsp_data;

   dma_bus_decode u_decode (
      .clk(clk), .rst_n(rst_n),
      .aw_valid(axi_aw_valid), .aw_id(axi_aw_id), .aw_addr(axi_aw_addr),
      .aw_size(axi_aw_size), .aw_ready(axi_aw_ready),
      .w_valid(axi_w_valid), .w_data(axi_w_data), .w_strb(axi_w_strb), .w_ready(axi_w_ready),
      .ar_valid(axi_ar_valid), .ar_id(axi_ar_id), .ar_addr(axi_ar_addr),
      .ar_size(axi_ar_size), .ar_ready(axi_ar_ready),
      .cmd_ready(cmd_ready), .cmd_valid(cmd_valid), .cmd(cmd), .held_any(held_any)
   );

   dma_entry_exec u_exec (
      .clk(clk), .rst_n(rst_n),
      .cmd_valid(cmd_valid), .cmd(cmd), .cmd_ready(cmd_ready),
      .mem_ready(mem_ready), .mem_rvalid(mem_rvalid), .mem_rtag(mem_rtag),
      .mem_rdata(mem_rdata), .mem_ecc_error(mem_ecc_error),
      .mem_req(mem_req), .mem_tag(mem_tag), .mem_addr(mem_addr), .mem_sz(mem_sz),
      .mem_write(mem_write), .mem_wdata(mem_wdata),
      .rsp_taken(rsp_taken), .rsp_valid(rsp_valid), .rsp_write(rsp_write),
      .rsp_id(rsp_id), .rsp_code(rsp_code), .rsp_data(rsp_data), .busy(busy)
   );

   dma_rsp_result u_rsp (
      .rsp_valid(rsp_valid), .rsp_write(rsp_write), .rsp_id(rsp_id),
      .rsp_code(rsp_code), .rsp_data(rsp_data),
      .bready(axi_bready), .rready(axi_rready),
      .bvalid(axi_bvalid), .bid(axi_bid), .bresp(axi_bresp),
      .rvalid(axi_rvalid), .rid(axi_rid), .rresp(axi_rresp),
      .rdata(axi_rdata), .rlast(axi_rlast), .rsp_taken(rsp_taken)
   );

   // Anything held or buffered counts as activity
   assign dma_active = busy | held_any;

endmodule

`default_nettype wire

//--- logic/dma_rsp_result.sv
`default_nettype none
`timescale 1ns/1ps

module dma_rsp_result (
   input logic rsp_valid,
   input logic rsp_write,
   input dma_pkg::axi_id_t rsp_id,
   input dma_pkg::axi_resp_t rsp_code,
   input dma_pkg::data_t rsp_data,
   input logic bready,
   input logic rready,
   output logic bvalid,
   output dma_pkg::axi_id_t bid,
   output dma_pkg::axi_resp_t bresp,
   output logic rvalid,
   output dma_pkg::axi_id_t rid,
   output dma_pkg::axi_resp_t rresp,
   output dma_pkg::data_t rdata,
   output logic rlast,
   output logic rsp_taken
);

   import dma_pkg::*;

   logic b_fire, r_fire;

   // Write entries answer on B, reads on R
   assign bvalid = rsp_valid & rsp_write;
   assign bid = rsp_id;
   assign bresp = rsp_code;

   assign rvalid = rsp_valid & ~rsp_write;
   assign rid = rsp_id;
   assign rresp = rsp_code;
   assign rdata = rsp_data;
   assign rlast = 1'b1;   // Every read is one beat

   assign b_fire = bvalid & bready;
   assign r_fire = rvalid & rready;
   assign rsp_taken = b_fire | r_fire;   // Frees the entry at the response pointer

endmodule

`default_nettype wire

//--- logic/dma_entry_exec.sv
`include "dma_settings.svh"
`default_nettype none
`timescale 1ns/1ps

module dma_entry_exec (
   input logic clk,
   input logic rst_n,
   input logic cmd_valid,
   input dma_pkg::bus_cmd_t cmd,
   output logic cmd_ready,
   input logic mem_ready,
   input logic mem_rvalid,
   input dma_pkg::ptr_t mem_rtag,
   input dma_pkg::data_t mem_rdata,
   input logic mem_ecc_error,
   output logic mem_req,
   output dma_pkg::ptr_t mem_tag,
   output dma_pkg::addr_t mem_addr,
   output dma_pkg::axi_size_t mem_sz,
   output logic mem_write,
   output dma_pkg::data_t mem_wdata,
   input logic rsp_taken,
   output logic rsp_valid,
   output logic rsp_write,
   output dma_pkg::axi_id_t rsp_id,
   output dma_pkg::axi_resp_t rsp_code,
   output dma_pkg::data_t rsp_data,
   output logic busy
);

   import dma_pkg::*;

   localparam int DEPTH = `DMA_DEPTH;
   localparam int PAD_W = `DMA_DATA_W - `DMA_ADDR_W;
   localparam addr_t DCCM_BASE = `DMA_DCCM_BASE;
   localparam addr_t DCCM_BYTES = `DMA_DCCM_KB * 1024;

   // Entry state
   logic [DEPTH-1:0] ent_valid, ent_done, ent_rpend;
   logic ent_write [DEPTH];
   axi_id_t ent_id [DEPTH];
   addr_t ent_addr [DEPTH];
   axi_size_t ent_size [DEPTH];
   strb_t ent_strb [DEPTH];
   data_t ent_data [DEPTH];
   axi_resp_t ent_code [DEPTH];

   ptr_t wr_ptr, iss_ptr, rsp_ptr;
   logic cmd_accept;
   logic chk_pend, in_dccm, addr_err, align_err, chk_err;
   addr_t iss_addr;
   axi_size_t iss_sz;
   strb_t iss_strb;
   logic narrow;
   logic [DEPTH-1:0] chk_hit, rtn_hit, done_set, rpend_set;

   function automatic ptr_t next_ptr(input ptr_t p);
      next_ptr = (p == ptr_t'(DEPTH - 1)) ? '0 : p + 1'b1;
   endfunction

   assign cmd_ready = ~ent_valid[wr_ptr];
   assign cmd_accept = cmd_valid & cmd_ready;

   // ********************
   // Checks at issue
   // ********************
   assign iss_addr = ent_addr[iss_ptr];
   assign iss_sz = ent_size[iss_ptr];
   assign iss_strb = ent_strb[iss_ptr];
   assign mem_write = ent_write[iss_ptr];

   assign chk_pend = ent_valid[iss_ptr] & ~ent_done[iss_ptr] & ~ent_rpend[iss_ptr];
   assign in_dccm = (iss_addr - DCCM_BASE) < DCCM_BYTES;   // Wraps high below the base
   assign addr_err = chk_pend & ~in_dccm;

   assign align_err = chk_pend & in_dccm &
      (((iss_sz == 3'd1) & iss_addr[0]) |
       ((iss_sz == 3'd2) & (|iss_addr[1:0])) |
       ((iss_sz == 3'd3) & (|iss_addr[2:0])) |
       (mem_write & ~((iss_sz == 3'd2) | (iss_sz == 3'd3))) |   // DCCM writes are word or dword
       (mem_write & (iss_sz == 3'd2) & (iss_strb[{iss_addr[2], 2'b00} +: 4] != 4'hf)) |
       (mem_write & (iss_sz == 3'd3) &
        ~((iss_strb == 8'h0f) | (iss_strb == 8'hf0) | (iss_strb == 8'hff))));

   assign chk_err = addr_err | align_err;

   // ********************
   // DCCM request
   // ********************
   assign mem_req = chk_pend & ~chk_err & mem_ready;
   assign mem_tag = iss_ptr;

   // Half-filled dword goes out as a word
   assign narrow = mem_write & (iss_sz == 3'd3) & ((iss_strb == 8'h0f) | (iss_strb == 8'hf0));
   assign mem_sz = narrow ? 3'd2 : iss_sz;
   assign mem_addr = (narrow & (iss_strb == 8'hf0)) ?
                     {iss_addr[`DMA_ADDR_W-1:3], 1'b1, iss_addr[1:0]} : iss_addr;
   assign mem_wdata = ent_data[iss_ptr];

   always_comb begin
      for (int i = 0; i < DEPTH; i++) begin
         chk_hit[i] = (iss_ptr == ptr_t'(i)) & (chk_err | mem_req);
         rtn_hit[i] = mem_rvalid & (mem_rtag == ptr_t'(i));
         done_set[i] = rtn_hit[i] | (chk_hit[i] & (chk_err | mem_write));   // Writes end at issue
         rpend_set[i] = chk_hit[i] & mem_req & ~mem_write;
      end
   end

   // ********************
   // Entry control
   // ********************
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         ent_valid <= '0;
         ent_done <= '0;
         ent_rpend <= '0;
         wr_ptr <= '0;
         iss_ptr <= '0;
         rsp_ptr <= '0;
      end else begin
         for (int i = 0; i < DEPTH; i++) begin
            if (rsp_taken && (rsp_ptr == ptr_t'(i))) begin
               ent_valid[i] <= 1'b0;
               ent_done[i] <= 1'b0;
               ent_rpend[i] <= 1'b0;
            end else begin
               if (cmd_accept && (wr_ptr == ptr_t'(i))) ent_valid[i] <= 1'b1;
               if (done_set[i]) ent_done[i] <= 1'b1;
               if (rpend_set[i]) ent_rpend[i] <= 1'b1;
            end
         end
         if (cmd_accept) wr_ptr <= next_ptr(wr_ptr);
         if (chk_err || mem_req) iss_ptr <= next_ptr(iss_ptr);
         if (rsp_taken) rsp_ptr <= next_ptr(rsp_ptr);
      end
   end

   always_ff @(posedge clk) begin
      for (int i = 0; i < DEPTH; i++) begin
         if (cmd_accept && (wr_ptr == ptr_t'(i))) begin
            ent_write[i] <= cmd.write;
            ent_id[i] <= cmd.id;
            ent_addr[i] <= cmd.addr;
            ent_size[i] <= cmd.size;
            ent_strb[i] <= cmd.strb;
            ent_data[i] <= cmd.data;
         end
         if (chk_hit[i] && chk_err) begin
            ent_code[i] <= addr_err ? `DMA_RESP_DECERR : `DMA_RESP_SLVERR;
            ent_data[i] <= {{PAD_W{1'b0}}, ent_addr[i]};   // Faulting address back as data
         end else if (chk_hit[i]) begin
            ent_code[i] <= `DMA_RESP_OKAY;
         end
         if (rtn_hit[i]) begin
            ent_code[i] <= mem_ecc_error ? `DMA_RESP_SLVERR : `DMA_RESP_OKAY;
            ent_data[i] <= mem_ecc_error ? {{PAD_W{1'b0}}, ent_addr[i]} : mem_rdata;
         end
      end
   end

   // Oldest entry toward the response stage
   assign rsp_valid = ent_valid[rsp_ptr] & ent_done[rsp_ptr];
   assign rsp_write = ent_write[rsp_ptr];
   assign rsp_id = ent_id[rsp_ptr];
   assign rsp_code = ent_code[rsp_ptr];
   assign rsp_data = ent_data[rsp_ptr];
   assign busy = |ent_valid;

   a_done_has_valid: assert property (@(posedge clk) disable iff (!rst_n)
      (ent_done & ~ent_valid) == '0);

endmodule

`default_nettype wire

//--- logic/dma_bus_decode.sv
`default_nettype none
`timescale 1ns/1ps

module dma_bus_decode (
   input logic clk,
   input logic rst_n,
   input logic aw_valid,
   input dma_pkg::axi_id_t aw_id,
   input dma_pkg::addr_t aw_addr,
   input dma_pkg::axi_size_t aw_size,
   output logic aw_ready,
   input logic w_valid,
   input dma_pkg::data_t w_data,
   input dma_pkg::strb_t w_strb,
   output logic w_ready,
   input logic ar_valid,
   input dma_pkg::axi_id_t ar_id,
   input dma_pkg::addr_t ar_addr,
   input dma_pkg::axi_size_t ar_size,
   output logic ar_ready,
   input logic cmd_ready,
   output logic cmd_valid,
   output dma_pkg::bus_cmd_t cmd,
   output logic held_any
);

   import dma_pkg::*;

   aw_payload_t aw_in, aw_held;
   w_payload_t w_in, w_held;
   ar_payload_t ar_in, ar_held;
   logic aw_held_valid, w_held_valid, ar_held_valid;
   logic wr_rdy, rd_rdy;
   logic sel_write;
   logic prio_write;   // Write wins a tie when set
   logic cmd_sent;
   logic wr_taken, rd_taken;

   assign aw_in = '{id: aw_id, addr: aw_addr, size: aw_size};
   assign w_in = '{data: w_data, strb: w_strb};
   assign ar_in = '{id: ar_id, addr: ar_addr, size: ar_size};

   // ********************
   // Channel holds
   // ********************
   dma_chan_hold #(.payload_t(aw_payload_t)) u_aw_hold (
      .clk(clk), .rst_n(rst_n), .in_valid(aw_valid), .in_data(aw_in), .cmd_taken(wr_taken),
      .in_ready(aw_ready), .held_valid(aw_held_valid), .held_data(aw_held)
   );

   dma_chan_hold #(.payload_t(w_payload_t)) u_w_hold (
      .clk(clk), .rst_n(rst_n), .in_valid(w_valid), .in_data(w_in), .cmd_taken(wr_taken),
      .in_ready(w_ready), .held_valid(w_held_valid), .held_data(w_held)
   );

   dma_chan_hold #(.payload_t(ar_payload_t)) u_ar_hold (
      .clk(clk), .rst_n(rst_n), .in_valid(ar_valid), .in_data(ar_in), .cmd_taken(rd_taken),
      .in_ready(ar_ready), .held_valid(ar_held_valid), .held_data(ar_held)
   );

   // ********************
   // Merge and arbitrate
   // ********************
   assign wr_rdy = aw_held_valid & w_held_valid;   // Write needs address and data
   assign rd_rdy = ar_held_valid;
   assign sel_write = (wr_rdy & rd_rdy) ? prio_write : wr_rdy;

   assign cmd_valid = wr_rdy | rd_rdy;
   assign cmd_sent = cmd_valid & cmd_ready;
   assign wr_taken = cmd_sent & sel_write;
   assign rd_taken = cmd_sent & ~sel_write;

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         prio_write <= 1'b1;
      end else if (cmd_sent) begin
         prio_write <= ~prio_write;
      end
   end

   assign cmd.write = sel_write;
   assign cmd.id = sel_write ? aw_held.id : ar_held.id;
   assign cmd.addr = sel_write ? aw_held.addr : ar_held.addr;
   assign cmd.size = sel_write ? aw_held.size : ar_held.size;
   assign cmd.data = w_held.data;
   assign cmd.strb = w_held.strb;

   assign held_any = aw_held_valid | w_held_valid | ar_held_valid;

endmodule

`default_nettype wire

//--- logic/dma_chan_hold.sv
`default_nettype none
`timescale 1ns/1ps

module dma_chan_hold #(
   parameter type payload_t = logic
) (
   input logic clk,
   input logic rst_n,
   input logic in_valid,
   input payload_t in_data,
   input logic cmd_taken,
   output logic in_ready,
   output logic held_valid,
   output payload_t held_data
);

   logic valid_q;
   payload_t data_q;
   logic load;

   // Free now, or emptied by the command leaving this cycle
   assign in_ready = ~valid_q | cmd_taken;
   assign load = in_valid & in_ready;

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         valid_q <= 1'b0;
      end else if (load) begin
         valid_q <= 1'b1;
      end else if (cmd_taken) begin
         valid_q <= 1'b0;
      end
   end

   always_ff @(posedge clk) begin
      if (load) begin
         data_q <= in_data;
      end
   end

   assign held_valid = valid_q;
   assign held_data = data_q;

   // A held request stays put until the merged command consumes it
   a_held_stable: assert property (@(posedge clk) disable iff (!rst_n)
      held_valid && !cmd_taken |=> $stable(held_data) && held_valid);

endmodule

`default_nettype wire

//--- logic/dma_pkg.sv
`include "dma_settings.svh"
`default_nettype none

package dma_pkg;

   typedef logic [`DMA_ADDR_W-1:0] addr_t;
   typedef logic [`DMA_DATA_W-1:0] data_t;
   typedef logic [`DMA_STRB_W-1:0] strb_t;
   typedef logic [`DMA_ID_W-1:0] axi_id_t;
   typedef logic [2:0] axi_size_t;   // log2 of the byte count
   typedef logic [1:0] axi_resp_t;
   typedef logic [$clog2(`DMA_DEPTH)-1:0] ptr_t;

   // Channel payloads as captured from the bus
   typedef struct packed {
      axi_id_t id;
      addr_t addr;
      axi_size_t size;
   } aw_payload_t;

   typedef struct packed {
      data_t data;
      strb_t strb;
   } w_payload_t;

   typedef struct packed {
      axi_id_t id;
      addr_t addr;
      axi_size_t size;
   } ar_payload_t;

   // One merged request toward the entry buffer
   typedef struct packed {
      logic write;
      axi_id_t id;
      addr_t addr;
      axi_size_t size;
      data_t data;
      strb_t strb;   // Don't care on reads
   } bus_cmd_t;

endpackage

`default_nettype wire

//--- logic/dma_settings.svh
`ifndef DMA_SETTINGS_SVH
`define DMA_SETTINGS_SVH

`default_nettype none

// ********************
// Bus widths
// ********************
`define DMA_ADDR_W 32
`define DMA_DATA_W 64
`define DMA_STRB_W 8   // One enable per data byte
`define DMA_ID_W 4

// Entry buffer
`define DMA_DEPTH 2

// ********************
// DCCM window
// ********************
`define DMA_DCCM_BASE 32'hf004_0000
`define DMA_DCCM_KB 64

// AXI response codes
`define DMA_RESP_OKAY 2'b00
`define DMA_RESP_SLVERR 2'b10
`define DMA_RESP_DECERR 2'b11

`default_nettype wire

`endif
